//--- logic/rvPkg.sv
package rvPkg;

    localparam int xlen      = 32;
    localparam int regAddrW  = 5;
    localparam int dmemWords = 256;
    localparam int dmemAddrW = $clog2(dmemWords);   // word index bits
    localparam int imemWords = 256;                 // instruction space served outside the core

    // major opcodes, instr[6:0]
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opSystem = 7'b1110011;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOpE;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immKindE;

    typedef enum logic {aRs1, aPc} aSrcE;

    typedef enum logic [1:0] {bRs2, bImm, bFour} bSrcE;

    // next pc choice
    typedef enum logic [1:0] {
        pcPlus4,    // sequential
        pcBranch,   // pc + imm, taken branch or jal
        pcJalr      // alu result, bit 0 cleared
    } pcSrcE;

    // lt/ge cover the unsigned forms too, the alu op tells them apart
    typedef enum logic [2:0] {brNone, brJal, brJalr, brEq, brNe, brLt, brGe} branchKindE;

    typedef struct packed {
        immKindE    immKind;
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
        aSrcE       aSrc;
        bSrcE       bSrc;
        aluOpE      aluOp;
        branchKindE branchKind;
        logic       isEcall;
    } ctrlT;

endpackage

//--- logic/controlUnit.sv
module controlUnit import rvPkg::*; (
    input  logic [xlen-1:0] instr,
    input  logic            isZero,
    input  logic            less,
    output ctrlT            ctrl,
    output pcSrcE           pcSrc
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    aluOpE      fnOp;       // alu op from funct3, shared by reg and imm forms

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    // sub only exists in reg form, addi has imm bits at [30]
    always_comb begin
        case (funct3)
            3'b000:  fnOp = (opcode == opReg && funct7b5) ? aluSub : aluAdd;
            3'b001:  fnOp = aluSll;
            3'b010:  fnOp = aluSlt;
            3'b011:  fnOp = aluSltu;
            3'b100:  fnOp = aluXor;
            3'b101:  fnOp = funct7b5 ? aluSra : aluSrl;   // srai keeps funct7 too
            3'b110:  fnOp = aluOr;
            default: fnOp = aluAnd;
        endcase
    end

    always_comb begin
        ctrl            = '0;
        ctrl.immKind    = immI;
        ctrl.aSrc       = aRs1;
        ctrl.bSrc       = bRs2;
        ctrl.aluOp      = aluAdd;
        ctrl.branchKind = brNone;
        case (opcode)
            opLui: begin
                ctrl.immKind  = immU;
                ctrl.regWrite = 1'b1;
                ctrl.bSrc     = bImm;       // x0 + imm
            end
            opAuipc: begin
                ctrl.immKind  = immU;
                ctrl.regWrite = 1'b1;
                ctrl.aSrc     = aPc;
                ctrl.bSrc     = bImm;
            end
            opJal: begin
                ctrl.immKind    = immJ;
                ctrl.regWrite   = 1'b1;
                ctrl.aSrc       = aPc;
                ctrl.bSrc       = bFour;    // link value pc + 4
                ctrl.branchKind = brJal;
            end
            opJalr: begin
                ctrl.immKind    = immI;
                ctrl.regWrite   = 1'b1;
                ctrl.bSrc       = bImm;     // alu forms the target
                ctrl.branchKind = brJalr;
            end
            opBranch: begin
                ctrl.immKind = immB;
                case (funct3)
                    3'b000:         ctrl.branchKind = brEq;
                    3'b001:         ctrl.branchKind = brNe;
                    3'b100, 3'b110: ctrl.branchKind = brLt;
                    3'b101, 3'b111: ctrl.branchKind = brGe;
                    default:        ctrl.branchKind = brNone;
                endcase
                if (!funct3[2]) begin
                    ctrl.aluOp = aluSub;    // eq/ne test isZero
                end else if (funct3[1]) begin
                    ctrl.aluOp = aluSltu;   // bltu/bgeu
                end else begin
                    ctrl.aluOp = aluSlt;
                end
            end
            opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.bSrc     = bImm;
            end
            opStore: begin
                ctrl.immKind  = immS;
                ctrl.memWrite = 1'b1;
                ctrl.bSrc     = bImm;
            end
            opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.bSrc     = bImm;
                ctrl.aluOp    = fnOp;
            end
            opReg: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = fnOp;
            end
            opSystem: ctrl.isEcall = (instr[31:7] == '0);   // other system ops act as nop
            default: ;
        endcase
    end

    // branch resolution from the alu flags
    always_comb begin
        case (ctrl.branchKind)
            brJal:   pcSrc = pcBranch;
            brJalr:  pcSrc = pcJalr;
            brEq:    pcSrc = isZero ? pcBranch : pcPlus4;
            brNe:    pcSrc = isZero ? pcPlus4 : pcBranch;
            brLt:    pcSrc = less ? pcBranch : pcPlus4;
            brGe:    pcSrc = less ? pcPlus4 : pcBranch;
            default: pcSrc = pcPlus4;
        endcase
    end

endmodule

//--- logic/immGen.sv
module immGen import rvPkg::*; (
    input  logic [xlen-1:0] instr,
    input  immKindE         immKind,
    output logic [xlen-1:0] imm
);

    logic sign;

    assign sign = instr[31];    // every format keeps its sign here

    always_comb begin
        case (immKind)
            immI: imm = {{(xlen-12){sign}}, instr[31:20]};
            immS: imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            immB: begin
                // bit 0 implied, bit 11 parked at instr[7]
                imm = {{(xlen-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            immU: imm = {instr[31:12], 12'b0};
            immJ: begin
                imm = {{(xlen-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

//--- logic/alu.sv
module alu import rvPkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  aluOpE           aluOp,
    output logic [xlen-1:0] result,
    output logic            isZero,
    output logic            less
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluOp)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluSll:  result = a << shamt;
            aluSlt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            aluSltu: result = {{(xlen-1){1'b0}}, a < b};
            aluXor:  result = a ^ b;
            aluSrl:  result = a >> shamt;
            aluSra:  result = $unsigned($signed(a) >>> shamt);
            aluOr:   result = a | b;
            aluAnd:  result = a & b;
            default: result = '0;
        endcase
    end

    // flags for branch resolution
    assign isZero = (result == '0);
    assign less   = result[0];      // only valid after slt/sltu

endmodule

//--- logic/regFile.sv
module regFile import rvPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic [regAddrW-1:0] rs1,
    input  logic [regAddrW-1:0] rs2,
    input  logic [regAddrW-1:0] rd,
    input  logic                wrEn,
    input  logic [xlen-1:0]     wrData,
    output logic [xlen-1:0]     rdData1,
    output logic [xlen-1:0]     rdData2
);

    logic [xlen-1:0] regs [2**regAddrW];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**regAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && rd != '0) begin   // x0 never written
            regs[rd] <= wrData;
        end
    end

    assign rdData1 = regs[rs1];
    assign rdData2 = regs[rs2];

    // x0 stays zero across every write
    assert property (@(posedge clk) disable iff (!arstN) (rs1 == '0) |-> (rdData1 == '0))
        else $error("regFile: x0 read back %h", rdData1);

endmodule

//--- logic/dataMem.sv
module dataMem import rvPkg::*; (
    input  logic            clk,
    input  logic [xlen-1:0] addr,
    input  logic            wrEn,
    input  logic [xlen-1:0] wrData,
    output logic [xlen-1:0] rdData
);

    logic [xlen-1:0]      mem [dmemWords];
    logic [dmemAddrW-1:0] wordIdx;

    assign wordIdx = addr[dmemAddrW+1:2];   // byte address to word index

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign rdData = mem[wordIdx];   // async read, same cycle as the load

    // only word stores exist
    assert property (@(posedge clk) wrEn |-> (addr[1:0] == 2'b00))
        else $error("dataMem: unaligned store to %h", addr);

endmodule

//--- logic/rvCore.sv
module rvCore import rvPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    output logic [xlen-1:0]     instrAddr,
    input  logic [xlen-1:0]     instr,
    output logic                commitValid,
    output logic [regAddrW-1:0] commitRd,
    output logic [xlen-1:0]     commitData,
    output logic                halted
);

    logic [xlen-1:0]     pc;
    logic [xlen-1:0]     pcPlus4Val;
    logic [xlen-1:0]     branchTarget;
    logic [xlen-1:0]     nextPc;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;
    logic [xlen-1:0]     aluA;
    logic [xlen-1:0]     aluB;
    logic [xlen-1:0]     aluResult;
    logic [xlen-1:0]     loadData;
    logic [xlen-1:0]     wbData;
    logic [regAddrW-1:0] rs1Idx;
    logic [regAddrW-1:0] rd;
    logic                isZero;
    logic                less;
    logic                regWrEn;
    logic                memWrEn;
    ctrlT                ctrl;
    pcSrcE               pcSrc;

    assign instrAddr = pc;
    assign rd        = instr[11:7];
    assign rs1Idx    = (instr[6:0] == opLui) ? '0 : instr[19:15];  // lui adds imm to x0

    // nothing retires once halted
    assign regWrEn = ctrl.regWrite && !halted;
    assign memWrEn = ctrl.memWrite && !halted;

    controlUnit u_controlUnit (
        .instr  (instr),
        .isZero (isZero),
        .less   (less),
        .ctrl   (ctrl),
        .pcSrc  (pcSrc)
    );

    immGen u_immGen (
        .instr   (instr),
        .immKind (ctrl.immKind),
        .imm     (imm)
    );

    regFile u_regFile (
        .clk     (clk),
        .arstN   (arstN),
        .rs1     (rs1Idx),
        .rs2     (instr[24:20]),
        .rd      (rd),
        .wrEn    (regWrEn),
        .wrData  (wbData),
        .rdData1 (rs1Data),
        .rdData2 (rs2Data)
    );

    assign aluA = (ctrl.aSrc == aPc) ? pc : rs1Data;

    always_comb begin
        case (ctrl.bSrc)
            bImm:    aluB = imm;
            bFour:   aluB = xlen'(4);
            default: aluB = rs2Data;
        endcase
    end

    alu u_alu (
        .a      (aluA),
        .b      (aluB),
        .aluOp  (ctrl.aluOp),
        .result (aluResult),
        .isZero (isZero),
        .less   (less)
    );

    dataMem u_dataMem (
        .clk    (clk),
        .addr   (aluResult),
        .wrEn   (memWrEn),
        .wrData (rs2Data),
        .rdData (loadData)
    );

    // writeback select
    always_comb begin
        if (ctrl.memRead) begin
            wbData = loadData;
        end else if (ctrl.branchKind == brJalr) begin
            wbData = pcPlus4Val;    // alu is busy with the jump target
        end else begin
            wbData = aluResult;     // jal link already pc + 4 here
        end
    end

    assign pcPlus4Val   = pc + xlen'(4);
    assign branchTarget = pc + imm;

    always_comb begin
        case (pcSrc)
            pcBranch: nextPc = branchTarget;
            pcJalr:   nextPc = {aluResult[xlen-1:1], 1'b0};
            default:  nextPc = pcPlus4Val;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc          <= '0;
            halted      <= 1'b0;
            commitValid <= 1'b0;
        end else begin
            if (!halted && !ctrl.isEcall) begin
                pc <= nextPc;   // ecall parks the pc on itself
            end
            if (ctrl.isEcall) begin
                halted <= 1'b1;
            end
            commitValid <= regWrEn && (rd != '0);
        end
    end

    // commit payload, qualified by commitValid
    always_ff @(posedge clk) begin
        if (regWrEn) begin
            commitRd   <= rd;
            commitData <= wbData;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("rvCore: pc %h not word aligned", pc);

endmodule

//--- tb/coreModel.svh
// expected alu result for reg and imm forms
function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] x,
                                       logic [31:0] y);
    logic [31:0] r;
    case (f3)
        3'd0: r = alt ? x - y : x + y;
        3'd1: r = x << y[4:0];
        3'd2: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        3'd3: r = (x < y) ? 32'd1 : 32'd0;
        3'd4: r = x ^ y;
        3'd5: r = alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'd6: r = x | y;
        default: r = x & y;
    endcase
    return r;
endfunction

// runs prog from pc 0 to the ecall and queues every nonzero rd write
function automatic void runModel();
    logic [31:0] regs [32];
    logic [31:0] dmem [int];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] iImm;
    logic [31:0] sImm;
    logic [31:0] bImmV;
    logic [31:0] jImm;
    logic [31:0] nextPc;
    logic [4:0]  rdIdx;
    logic [2:0]  f3;
    logic        wr;
    logic        taken;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    pc = '0;
    for (int steps = 0; steps < 1000; steps++) begin
        ins = prog[pc[9:2]];
        if (ins == 32'h0000_0073) break;    // ecall
        rdIdx  = ins[11:7];
        f3     = ins[14:12];
        a      = regs[ins[19:15]];
        b      = regs[ins[24:20]];
        iImm   = {{20{ins[31]}}, ins[31:20]};
        sImm   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        bImmV  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        jImm   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        nextPc = pc + 32'd4;
        wr     = 1'b1;
        res    = '0;
        case (ins[6:0])
            opLui:   res = {ins[31:12], 12'b0};
            opAuipc: res = pc + {ins[31:12], 12'b0};
            opJal: begin
                res    = pc + 32'd4;
                nextPc = pc + jImm;
            end
            opJalr: begin
                res    = pc + 32'd4;
                nextPc = (a + iImm) & ~32'd1;
            end
            opBranch: begin
                wr = 1'b0;
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) nextPc = pc + bImmV;
            end
            opLoad:  res = dmem[int'(((a + iImm) >> 2) & 32'hff)];
            opStore: begin
                wr = 1'b0;
                dmem[int'(((a + sImm) >> 2) & 32'hff)] = b;
            end
            opImm:   res = aluRef(f3, (f3 == 3'd5) && ins[30], a, iImm);
            opReg:   res = aluRef(f3, ins[30], a, b);
            default: wr = 1'b0;
        endcase
        if (wr && rdIdx != 5'd0) begin
            regs[rdIdx] = res;
            expRd.push_back(rdIdx);
            expData.push_back(res);
            expCat.push_back(progCat[pc[9:2]]);
        end
        pc = nextPc;
    end
endfunction

//--- tb/tbCore.sv
module tbCore import rvPkg::*; ();

    localparam int period  = 4;
    localparam int progLen = 200;

    logic                clk = 1'b0;
    logic                arstN;
    logic [xlen-1:0]     instrAddr;
    logic [xlen-1:0]     instr;
    logic                commitValid;
    logic [regAddrW-1:0] commitRd;
    logic [xlen-1:0]     commitData;
    logic                halted;

    logic [31:0] prog [imemWords];
    int          progCat [imemWords];  // test number that owns each slot
    int          kind [imemWords];
    bit          groupStart [imemWords];
    logic [4:0]  expRd [$];
    logic [31:0] expData [$];
    int          expCat [$];
    int          errs [6];
    int          seen [6];
    int          passed;
    int          failedChecks;
    logic [4:0]  popRd;
    logic [31:0] popData;
    int          popCat;

    `include "coreModel.svh"

    always #(period / 2) clk = ~clk;

    rvCore u_rvCore (
        .clk         (clk),
        .arstN       (arstN),
        .instrAddr   (instrAddr),
        .instr       (instr),
        .commitValid (commitValid),
        .commitRd    (commitRd),
        .commitData  (commitData),
        .halted      (halted)
    );

    always_comb instr = prog[instrAddr[9:2]];   // combinational instruction port

    function automatic logic [4:0] pickReg();
        return ($urandom % 8 == 0) ? 5'd0 : 5'($urandom);
    endfunction

    // first group start at or after j
    function automatic int landing(int j);
        int t;
        t = (j > progLen - 1) ? progLen - 1 : j;
        while (!groupStart[t]) t++;
        return t;
    endfunction

    task automatic genProgram();
        int i;
        int r;
        int t;
        logic [2:0]  f3;
        logic [11:0] im;
        logic [12:0] bo;
        logic [20:0] jo;
        logic [4:0]  base;
        for (int k = 0; k < imemWords; k++) begin
            prog[k]       = 32'h0000_0073;
            kind[k]       = 0;
            progCat[k]    = 5;
            groupStart[k] = (k >= progLen - 1);
        end
        i = 0;
        while (i < progLen - 1) begin
            r = $urandom % 10;
            groupStart[i] = 1'b1;
            if (r <= 2) begin                                  // reg-reg
                f3 = 3'($urandom);
                prog[i] = {1'b0, (f3 == 0 || f3 == 5) ? 1'($urandom) : 1'b0, 5'b0,
                           5'($urandom), 5'($urandom), f3, pickReg(), opReg};
                progCat[i] = 1;
                i++;
            end else if (r == 5 && i + 2 < progLen) begin      // store then load
                im = 12'(($urandom % 128) * 4);
                prog[i]     = {im[11:5], 5'($urandom), 5'd0, 3'b010, im[4:0], opStore};
                prog[i + 1] = {im, 5'd0, 3'b010, pickReg(), opLoad};
                progCat[i] = 3;
                progCat[i + 1] = 3;
                i += 2;
            end else if (r >= 6 && r <= 8) begin               // branch or jal, patched later
                kind[i] = (r == 8) ? 2 : 1;
                progCat[i] = 4;
                i++;
            end else if (r == 9 && i + 3 < progLen) begin      // lui/addi base then jalr
                kind[i + 2] = 3;
                progCat[i] = 2;
                progCat[i + 1] = 2;
                progCat[i + 2] = 4;
                i += 3;
            end else begin                                     // imm forms, lui, auipc
                f3 = 3'($urandom);
                im = 12'($urandom);
                if (f3 == 1) im = {7'b0, im[4:0]};
                if (f3 == 5) im = {1'b0, im[10], 5'b0, im[4:0]};
                r = $urandom % 5;
                if (r == 3) prog[i] = {20'($urandom), pickReg(), opLui};
                else if (r == 4) prog[i] = {20'($urandom), pickReg(), opAuipc};
                else prog[i] = {im, 5'($urandom), f3, pickReg(), opImm};
                progCat[i] = 2;
                i++;
            end
        end
        for (int k = 0; k < progLen - 1; k++) begin
            if (kind[k] == 1) begin
                t  = landing(k + 1 + $urandom % 12);
                bo = 13'((t - k) * 4);
                f3 = 3'($urandom % 6);
                f3 = (f3 >= 2) ? f3 + 3'd2 : f3;               // 0,1,4..7
                prog[k] = {bo[12], bo[10:5], 5'($urandom), 5'($urandom), f3,
                           bo[4:1], bo[11], opBranch};
            end else if (kind[k] == 2) begin
                t  = landing(k + 1 + $urandom % 12);
                jo = 21'((t - k) * 4);
                prog[k] = {jo[20], jo[10:1], jo[11], jo[19:12], pickReg(), opJal};
            end else if (kind[k] == 3) begin
                t    = landing(k + 1 + $urandom % 12);
                base = 5'(1 + $urandom % 31);
                prog[k - 2] = {20'd0, base, opLui};
                prog[k - 1] = {12'(t * 4), base, 3'b000, base, opImm};
                prog[k]     = {11'd0, 1'($urandom), base, 3'b000, pickReg(), opJalr};
            end
        end
    endtask

    // commit checker, sampled away from the rising edge
    always @(negedge clk) begin
        if (arstN && commitValid) begin
            if (halted) begin
                $display("error at %0t: commit of x%0d after halt", $time, commitRd);
                errs[5]++;
            end
            if (expRd.size() == 0) begin
                $display("error at %0t: commit of x%0d with no expected write left",
                         $time, commitRd);
                errs[5]++;
            end else begin
                popRd   = expRd.pop_front();
                popData = expData.pop_front();
                popCat  = expCat.pop_front();
                seen[popCat]++;
                if (commitRd !== popRd) begin
                    $display("mismatch at %0t: commitRd expected %0d got %0d",
                             $time, popRd, commitRd);
                    errs[popCat]++;
                end
                if (commitData !== popData) begin
                    $display("mismatch at %0t: commitData expected %h got %h",
                             $time, popData, commitData);
                    errs[popCat]++;
                end
            end
        end
    end

    initial begin
        #((10 + 10 * progLen) * period);
        $display("error: the core never halted within %0d cycles", 10 * progLen);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        string names [6];
        bit    ok;
        names[1] = "register-register alu";
        names[2] = "immediate alu, lui, auipc, x0 writes";
        names[3] = "store then load";
        names[4] = "branches, jal, jalr";
        names[5] = "ecall halt";
        void'($urandom(32'h279b66f0));
        arstN = 1'b0;
        genProgram();
        runModel();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        wait (halted);
        repeat (20) @(negedge clk);
        passed = 0;
        failedChecks = 0;
        for (int n = 1; n <= 5; n++) begin
            if (n == 5) ok = halted && expRd.size() == 0 && errs[5] == 0;
            else ok = (errs[n] == 0) && (seen[n] > 0);
            if (n == 5 && expRd.size() != 0)
                $display("error: %0d expected writes never committed", expRd.size());
            if (n < 5 && seen[n] == 0) $display("error: test %0d saw no commits", n);
            $display("test %0d %s: %s (%0d commits, %0d errors)", n, names[n],
                     ok ? "pass" : "fail", seen[n], errs[n]);
            if (ok) passed++;
            failedChecks += errs[n];
        end
        $display("%0d of 5 tests passed, %0d failed checks", passed, failedChecks);
        if (passed == 5) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+tb
logic/rvPkg.sv
logic/controlUnit.sv
logic/immGen.sv
logic/alu.sv
logic/regFile.sv
logic/dataMem.sv
logic/rvCore.sv
tb/tbCore.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then decide on the log
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tbCore \
    -f vlog.f -o simCore > build.log 2>&1 \
    && ./obj_dir/simCore > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation reported failure"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
exit 0
